//--- filelist.f
+incdir+rtl
rtl/execPkg.sv
rtl/alu.sv
rtl/operandSelect.sv
rtl/branchUnit.sv
rtl/executeStage.sv
tb/executeChecker.sv
tb/executeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/executeTb

verilator --binary --timing --assert -j 0 \
    --top-module executeTb \
    --Mdir obj_dir -o executeTb \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb/executeTb.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module executeTb;
    import execPkg::*;

    localparam int NUM_TX     = 2000;
    localparam int CLK_PERIOD = 10;
    localparam int TIMEOUT_NS = NUM_TX * 10 * CLK_PERIOD + 5000;  // 10 cycles per instr, margin

    logic        clk;
    logic        rst;
    logic        inValid;
    issueT       inInstr;
    logic        stall;
    logic        outValid;
    exOutT       outData;
    int          pending;
    int          acceptedCount = 0;
    int          drainCycles;
    int          failures;
    int unsigned firstDraw;

    // ARITH weighted up, ten ops times two B sources
    function automatic opClassE pickClass();
        case ($urandom_range(9, 0))
            0, 1, 2: return ARITH;
            3, 4:    return BRANCH;
            5:       return LOADSTORE;
            6:       return LUI;
            7:       return AUIPC;
            8:       return JAL;
            default: return JALR;
        endcase
    endfunction

    function automatic aluOpE pickAluOp();
        case ($urandom_range(9, 0))
            0:       return ADD;
            1:       return SUB;
            2:       return SLL;
            3:       return SLT;
            4:       return SLTU;
            5:       return XOR;
            6:       return SRL;
            7:       return SRA;
            8:       return OR;
            default: return AND;
        endcase
    endfunction

    function automatic brCondE pickCond();
        case ($urandom_range(5, 0))
            0:       return BEQ;
            1:       return BNE;
            2:       return BLT;
            3:       return BGE;
            4:       return BLTU;
            default: return BGEU;
        endcase
    endfunction

    function automatic issueT randomInstr();
        issueT            instr;
        logic [`XLEN-1:0] base;
        base           = $urandom;
        instr.rs1Value = base;
        case ($urandom_range(3, 0))
            0:       instr.rs2Value = base;                // Equal operands
            1:       instr.rs2Value = base ^ 32'h8000_0000; // Sign flipped
            2:       instr.rs2Value = base + $urandom_range(2, 0) - 1; // Off by one
            default: instr.rs2Value = $urandom;
        endcase
        instr.imm            = $urandom;
        instr.pc             = $urandom & 32'hFFFF_FFFC;   // Word aligned
        instr.opClass        = pickClass();
        instr.aluOp          = pickAluOp();
        instr.aluSrcImm      = 1'($urandom);
        instr.brCond         = pickCond();
        instr.ctrl.memWrite  = 1'($urandom);
        instr.ctrl.memRead   = 1'($urandom);
        instr.ctrl.regWrite  = 1'($urandom);
        instr.ctrl.regDest   = `REG_ADDR_W'($urandom);
        instr.ctrl.memToReg  = 1'($urandom);
        return instr;
    endfunction

    // Falling edge stimulus, held while stalled
    task automatic driveCycle();
        if (!stall)
        begin
            inValid = ($urandom_range(99, 0) < 80);
            inInstr = randomInstr();
        end
        stall = ($urandom_range(99, 0) < 20);
    endtask

    executeStage dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inInstr  (inInstr),
        .stall    (stall),
        .outValid (outValid),
        .outData  (outData)
    );

    executeChecker chk (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inInstr  (inInstr),
        .stall    (stall),
        .outValid (outValid),
        .outData  (outData),
        .pending  (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!rst && inValid && !stall)
            acceptedCount++;    // Same handshake the stage uses
    end

    initial
    begin
        firstDraw = $urandom(59325);
        rst       = 1'b1;
        inValid   = 1'b0;
        stall     = 1'b0;
        inInstr   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (acceptedCount < NUM_TX)
        begin
            @(negedge clk);
            if (acceptedCount < NUM_TX)
                driveCycle();
        end
        inValid = 1'b0;
        stall   = 1'b0;

        // Let the last instruction leave the register
        drainCycles = 0;
        while ((outValid || pending != 0) && drainCycles < 20)
        begin
            @(negedge clk);
            drainCycles++;
        end

        failures = chk.summarize();
        if (failures == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, %0d of %0d instructions accepted",
                 TIMEOUT_NS, acceptedCount, NUM_TX);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb/executeChecker.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module executeChecker (
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    input  execPkg::issueT inInstr,
    input  logic           stall,
    input  logic           outValid,
    input  execPkg::exOutT outData,
    output int             pending      // Instructions accepted but not yet seen
);
    import execPkg::*;

    exOutT   expQ[$];
    opClassE classQ[$];     // Context for error lines
    int      seqQ[$];
    int      issuedCount  = 0;
    int      checkedCount = 0;
    int      valueErrors  = 0;
    int      orderErrors  = 0;
    int      resetErrors  = 0;
    logic    resetWindow  = 1'b1;   // Until the first accepted instruction

    // RV32I integer ops written from the ISA definitions
    function automatic logic [`XLEN-1:0] expectedAlu(aluOpE op, logic [`XLEN-1:0] a,
                                                     logic [`XLEN-1:0] b);
        int unsigned      sh;
        logic [`XLEN-1:0] fill;
        logic             aLessSigned;
        sh          = int'(b[4:0]);
        fill        = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;   // Sign copies on top
        aLessSigned = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + `XLEN'(1);     // Two's complement
            SLL:     return a << sh;
            SLT:     return `XLEN'(aLessSigned);
            SLTU:    return `XLEN'(a < b);
            XOR:     return a ^ b;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | fill;
            OR:      return a | b;
            AND:     return a & b;
            default: return '0;
        endcase
    endfunction

    function automatic logic branchTaken(issueT i);
        logic eq;
        logic ltu;
        logic lt;
        eq  = i.rs1Value == i.rs2Value;
        ltu = i.rs1Value < i.rs2Value;
        // Different signs decide it, same signs compare like unsigned
        lt  = (i.rs1Value[`XLEN-1] != i.rs2Value[`XLEN-1]) ? i.rs1Value[`XLEN-1] : ltu;
        case (i.brCond)
            BEQ:     return eq;
            BNE:     return !eq;
            BLT:     return lt;
            BGE:     return !lt;
            BLTU:    return ltu;
            BGEU:    return !ltu;
            default: return 1'b0;
        endcase
    endfunction

    function automatic exOutT predictOutput(issueT i);
        exOutT            exp;
        logic [`XLEN-1:0] jumpBase;
        exp      = '0;
        jumpBase = i.rs1Value + i.imm;
        case (i.opClass)
            LOADSTORE: exp.result = i.rs1Value + i.imm;
            BRANCH:    exp.result = i.rs1Value + i.rs2Value;  // Forced ADD, unused
            ARITH:     exp.result = expectedAlu(i.aluOp, i.rs1Value,
                                                i.aluSrcImm ? i.imm : i.rs2Value);
            LUI:       exp.result = i.imm;
            AUIPC:     exp.result = i.pc + i.imm;
            JAL, JALR: exp.result = i.pc + `XLEN'(`PC_STEP);  // Link address
            default:   exp.result = '0;
        endcase
        exp.storeData = i.rs2Value;
        exp.ctrl      = i.ctrl;
        exp.redirect  = (i.opClass == BRANCH) ? branchTaken(i)
                                              : (i.opClass == JAL || i.opClass == JALR);
        exp.target    = (i.opClass == JALR) ? (jumpBase & ~`XLEN'(1)) : i.pc + i.imm;
        return exp;
    endfunction

    task automatic checkField(string field, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp,
                              int seq, opClassE cls);
        if (got !== exp)
        begin
            valueErrors++;
            $display("ERR %0d ns: instr %0d (%s) %s got %h expected %h",
                     $time, seq, cls.name(), field, got, exp);
        end
    endtask

    task automatic compareOutput(exOutT got, exOutT exp, int seq, opClassE cls);
        checkedCount++;
        checkField("result", got.result, exp.result, seq, cls);
        checkField("storeData", got.storeData, exp.storeData, seq, cls);
        checkField("ctrl", `XLEN'(got.ctrl), `XLEN'(exp.ctrl), seq, cls);
        checkField("redirect", `XLEN'(got.redirect), `XLEN'(exp.redirect), seq, cls);
        checkField("target", got.target, exp.target, seq, cls);
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            expQ.delete();
            classQ.delete();
            seqQ.delete();
            resetWindow = 1'b1;
        end
        else
        begin
            if (resetWindow && (outValid || outData.redirect || outData.ctrl != '0))
            begin
                resetErrors++;
                $display("ERR %0d ns: output not idle after reset, valid %b redirect %b ctrl %h",
                         $time, outValid, outData.redirect, outData.ctrl);
            end
            // One register deep, one cycle late: outValid means exactly one outstanding
            if (expQ.size() != (outValid ? 1 : 0))
            begin
                orderErrors++;
                $display("Stage shows outValid %b at %0d ns with %0d instructions outstanding",
                         outValid, $time, expQ.size());
            end
            // Pop before push, outData still shows the older instruction
            if (outValid && !stall && expQ.size() != 0)
                compareOutput(outData, expQ.pop_front(), seqQ.pop_front(),
                              classQ.pop_front());
            if (inValid && !stall)
            begin
                expQ.push_back(predictOutput(inInstr));
                classQ.push_back(inInstr.opClass);
                seqQ.push_back(issuedCount);
                issuedCount++;
                resetWindow = 1'b0;
            end
        end
        pending = expQ.size();
    end

    function automatic int summarize();
        int leftover;
        leftover = expQ.size();
        if (leftover != 0)
            $display("%0d accepted instructions never left the stage", leftover);
        $display("Checker: %0d issued, %0d checked, errors value %0d order %0d reset %0d lost %0d",
                 issuedCount, checkedCount, valueErrors, orderErrors, resetErrors, leftover);
        return valueErrors + orderErrors + resetErrors + leftover;
    endfunction

endmodule

//--- rtl/executeStage.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module executeStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    input  execPkg::issueT inInstr,
    input  logic           stall,     // Memory stage cannot take outData
    output logic           outValid,
    output execPkg::exOutT outData
);
    import execPkg::*;

    logic             validReg;       // Register holds a live instruction
    issueT            instrReg;       // Decoded instruction in flight
    logic             accept;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    aluOpE            aluOp;
    logic [`XLEN-1:0] aluResult;

    logic             brRedirect;
    logic [`XLEN-1:0] brTarget;

    // Handshake toward decode
    assign accept = inValid && !stall;

    // Input pipeline register, one instruction deep
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            validReg <= 1'b0;
            instrReg <= '0;         // LOADSTORE, no ctrl bits, no redirect
        end
        else
        begin
            if (!stall)
                validReg <= inValid;    // Bubble when decode has nothing
            if (accept)
                instrReg <= inInstr;    // Stall or bubble keeps the old one
        end
    end

    // Operand A/B by class, op forced to ADD outside ARITH
    operandSelect uOperandSelect (
        .instr (instrReg),
        .opA   (opA),
        .opB   (opB),
        .op    (aluOp)
    );

    alu uAlu (
        .a      (opA),
        .b      (opB),
        .op     (aluOp),
        .result (aluResult)
    );

    // Condition and target work straight from the register
    branchUnit uBranchUnit (
        .instr    (instrReg),
        .redirect (brRedirect),
        .target   (brTarget)
    );

    assign outValid = validReg;

    always_comb
    begin
        outData.result    = aluResult;
        outData.storeData = instrReg.rs2Value;  // Store data skips the ALU
        outData.ctrl      = instrReg.ctrl;      // Pass-through to mem and wb
        outData.redirect  = brRedirect;
        outData.target    = brTarget;
    end

    // Nothing may leak out of a freshly reset stage
    assert property (@(posedge clk) $fell(rst) |-> !outValid)
    else $error("executeStage: outValid high right after reset");

    // Downstream relies on a frozen output while it stalls us
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(outValid) && $stable(outData))
    else $error("executeStage: output moved during stall");

endmodule

//--- rtl/branchUnit.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module branchUnit (
    input  execPkg::issueT   instr,
    output logic             redirect,
    output logic [`XLEN-1:0] target
);
    import execPkg::*;

    logic             isEq;
    logic             ltSigned;
    logic             ltUnsigned;
    logic             condHolds;
    logic [`XLEN-1:0] jalrSum;

    assign isEq       = instr.rs1Value == instr.rs2Value;
    assign ltSigned   = $signed(instr.rs1Value) < $signed(instr.rs2Value);
    assign ltUnsigned = instr.rs1Value < instr.rs2Value;
    assign jalrSum    = instr.rs1Value + instr.imm;     // JALR base plus offset

    always_comb
    begin
        case (instr.brCond)
            BEQ:     condHolds = isEq;
            BNE:     condHolds = !isEq;
            BLT:     condHolds = ltSigned;
            BGE:     condHolds = !ltSigned;
            BLTU:    condHolds = ltUnsigned;
            BGEU:    condHolds = !ltUnsigned;
            default: condHolds = 1'b0;  // Unknown condition never taken
        endcase
    end

    always_comb
    begin
        redirect = 1'b0;
        target   = instr.pc + instr.imm;    // Branch and JAL target
        case (instr.opClass)
            BRANCH: redirect = condHolds;
            JAL:    redirect = 1'b1;
            JALR:
            begin
                redirect = 1'b1;
                target   = {jalrSum[`XLEN-1:1], 1'b0};  // Bit 0 cleared per ISA
            end
            default: redirect = 1'b0;
        endcase
    end

    // A redirect from anything but a control transfer would corrupt fetch
    always_comb
    begin
        if (!$isunknown(redirect) && redirect)
        begin
            assert (instr.opClass inside {BRANCH, JAL, JALR})
            else $error("branchUnit: redirect from class %b", instr.opClass);
        end
    end

endmodule

//--- rtl/operandSelect.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module operandSelect (
    input  execPkg::issueT   instr,
    output logic [`XLEN-1:0] opA,
    output logic [`XLEN-1:0] opB,
    output execPkg::aluOpE   op
);
    import execPkg::*;

    always_comb
    begin
        // Defaults keep the block latch free
        opA = '0;
        opB = '0;
        op  = ADD;      // Address, upper-imm and link math are all adds

        case (instr.opClass)
            LOADSTORE:
            begin
                opA = instr.rs1Value;   // Effective address rs1 + imm
                opB = instr.imm;
            end
            BRANCH:
            begin
                // Result unused, branchUnit decides
                opA = instr.rs1Value;
                opB = instr.rs2Value;
            end
            ARITH:
            begin
                opA = instr.rs1Value;
                opB = instr.aluSrcImm ? instr.imm : instr.rs2Value; // I-type vs R-type
                op  = instr.aluOp;      // Only class that keeps its own op
            end
            LUI:
            begin
                opA = '0;               // Zero plus upper immediate
                opB = instr.imm;
            end
            AUIPC:
            begin
                opA = instr.pc;
                opB = instr.imm;
            end
            JAL, JALR:
            begin
                // Link address pc + 4 goes to rd
                opA = instr.pc;
                opB = `XLEN'(`PC_STEP);
            end
            default:
            begin
                opA = '0;               // Unused class code, harmless add
                opB = '0;
            end
        endcase
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  execPkg::aluOpE   op,
    output logic [`XLEN-1:0] result
);
    import execPkg::*;

    logic [4:0] shamt;      // RV32 shifts only look at b[4:0]
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb
    begin
        case (op)
            ADD:  result = a + b;
            SUB:  result = a - b;
            SLL:  result = a << shamt;
            SLT:  result = {{(`XLEN-1){1'b0}}, ltSigned};   // 0 or 1
            SLTU: result = {{(`XLEN-1){1'b0}}, ltUnsigned};
            XOR:  result = a ^ b;
            SRL:  result = a >> shamt;                      // Zero fill
            SRA:  result = $unsigned($signed(a) >>> shamt); // Sign fill
            OR:   result = a | b;
            AND:  result = a & b;
            default:
            begin
                result = '0;    // Unreachable with a sane decoder
            end
        endcase
    end

    // Decode and operand select must never hand over a gap in the op table
    always_comb
    begin
        if (!$isunknown(op))
        begin
            assert (op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND})
            else $error("alu: unlisted op encoding %b", op);
        end
    end

endmodule

//--- rtl/execPkg.sv
`include "exec_macros.svh"

package execPkg;

    // ALU operation, encoded as {funct7[5], funct3} of the R-type
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } aluOpE;

    // Operand class from decode, 3'b110 unused
    typedef enum logic [2:0] {
        LOADSTORE = 3'b000,
        BRANCH    = 3'b001,
        ARITH     = 3'b010,
        JAL       = 3'b011,
        LUI       = 3'b100,
        AUIPC     = 3'b101,
        JALR      = 3'b111
    } opClassE;

    // Branch condition, same as funct3 of the B-type
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } brCondE;

    // Bits carried untouched toward memory and writeback
    typedef struct packed {
        logic                   memWrite;
        logic                   memRead;
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] regDest;
        logic                   memToReg;
    } ctrlT;

    // One decoded instruction as it leaves decode
    typedef struct packed {
        logic [`XLEN-1:0] rs1Value;
        logic [`XLEN-1:0] rs2Value;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] pc;
        opClassE          opClass;
        aluOpE            aluOp;      // Only honoured for ARITH
        logic             aluSrcImm;  // ARITH only, imm replaces rs2 as B
        brCondE           brCond;
        ctrlT             ctrl;
    } issueT;

    // Stage output toward the memory stage
    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] storeData;
        ctrlT             ctrl;
        logic             redirect;   // Fetch must restart at target
        logic [`XLEN-1:0] target;
    } exOutT;

endpackage

//--- rtl/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// RV32 datapath and address width
`define XLEN 32

// Register index, x0..x31
`define REG_ADDR_W 5

// Link increment for JAL and JALR
`define PC_STEP 4

`endif
